// ==== memAlign.f ====
source/alignPkg.sv
source/tlbTable.sv
source/accessSplitter.sv
source/alignStage.sv
source/memAlignTop.sv
tb/memAlign_sva.sv
tb/memAlignTb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module memAlignTb -Mdir obj_dir -f memAlign.f &&
    ./obj_dir/VmemAlignTb +verilator+error+limit+100 | tee /dev/stderr |
    grep -qx 'TB PASSED' &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }

// ==== source/accessSplitter.sv ====
`timescale 1ns/10ps

module accessSplitter import alignPkg::*; (
    input  vAddrT    vAddr,
    input  sizeCodeT size,
    input  lineDataT dataIn,
    input  logic     fromBus,
    output splitT    split,
    output vpnT      vpn0,
    output vpnT      vpn1
);

    lineOffsetT offset;
    byteCountT  bytes;
    byteCountT  endSum;
    byteCountT  bytes0;
    byteCountT  bytes1;
    logic       crosses;
    vAddrT      lineAddr0;
    vAddrT      lineAddr1;
    byteMaskT   shiftedMask;
    lineDataT   shiftedData;

    // n ones from byte 0 upward
    function automatic byteMaskT lowOnes(input byteCountT n);
        logic [lineBytes:0] wide;
        wide = ({{lineBytes{1'b0}}, 1'b1} << n) - 1'b1;
        return wide[lineBytes-1:0];
    endfunction

    assign offset = vAddr[lineOffsetBits-1:0];

    // size code to byte count
    assign bytes = byteCountT'(1) << size;

    assign endSum = byteCountT'(offset) + bytes;
    assign crosses = endSum > byteCountT'(lineBytes);

    // first line takes what fits, second line the rest
    assign bytes0 = crosses ? byteCountT'(lineBytes) - byteCountT'(offset) : bytes;
    assign bytes1 = bytes - bytes0;

    // line-aligned addresses
    assign lineAddr0 = {vAddr[31:lineOffsetBits], {lineOffsetBits{1'b0}}};
    assign lineAddr1 = lineAddr0 + vAddrT'(lineBytes);

    assign vpn0 = lineAddr0[31:pageBits];
    assign vpn1 = lineAddr1[31:pageBits];

    // first line, data and mask moved up to the byte offset
    assign shiftedMask = lowOnes(bytes0) << offset;
    assign shiftedData = dataIn << {offset, 3'b000};

    always_comb begin
        split.vAddr0 = lineAddr0;
        split.vAddr1 = lineAddr1;

        // a bus fill is a whole line already in place
        if (fromBus) begin
            split.mask0 = '1;
            split.data0 = dataIn;
            split.mask1 = '0;
            split.needSecond = 1'b0;
        end else begin
            split.mask0 = shiftedMask;
            split.data0 = shiftedData;
            split.mask1 = lowOnes(bytes1);
            split.needSecond = crosses;
        end

        // bytes left over after the first line, starting at byte 0
        split.data1 = dataIn >> {bytes0, 3'b000};
    end

endmodule

// ==== source/alignPkg.sv ====
package alignPkg;

    // line and page geometry
    localparam int lineBytes = 16;
    localparam int lineOffsetBits = $clog2(lineBytes);
    localparam int pageBits = 12;

    typedef logic [31:0] vAddrT;
    // frame on top of the page offset
    typedef logic [14:0] pAddrT;
    typedef logic [19:0] vpnT;
    typedef logic [2:0] frameT;
    typedef logic [8*lineBytes-1:0] lineDataT;
    typedef logic [lineBytes-1:0] byteMaskT;
    // 0..3 select 1, 2, 4, 8 bytes
    typedef logic [1:0] sizeCodeT;
    typedef logic [lineOffsetBits-1:0] lineOffsetT;
    // wide enough for offset plus access size
    typedef logic [lineOffsetBits:0] byteCountT;

    typedef struct packed {
        logic  valid;
        logic  present;
        logic  writable;
        logic  cacheDisable;
        vpnT   vpn;
        frameT frame;
    } tlbEntryT;

    typedef struct packed {
        logic  hit;
        logic  present;
        logic  writable;
        logic  cacheDisable;
        frameT frame;
    } tlbResultT;

    typedef struct packed {
        logic     valid;
        logic     write;
        vAddrT    vAddr;
        pAddrT    pAddr;
        lineDataT data;
        byteMaskT mask;
    } lineReqT;

    typedef struct packed {
        vAddrT    vAddr0;
        vAddrT    vAddr1;
        lineDataT data0;
        lineDataT data1;
        byteMaskT mask0;
        byteMaskT mask1;
        logic     needSecond;
    } splitT;

    // status of one lookup, ORed over the lines in use
    typedef struct packed {
        logic tlbMiss;
        logic protFault;
        logic uncached;
    } statusT;

endpackage

// ==== source/alignStage.sv ====
`timescale 1ns/10ps

module alignStage import alignPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      validIn,
    input  logic      write,
    input  splitT     split,
    input  tlbResultT tlb0,
    input  tlbResultT tlb1,
    output lineReqT   req0,
    output lineReqT   req1,
    output logic      tlbMiss,
    output logic      protFault,
    output logic      uncached
);

    lineReqT next0;
    lineReqT next1;
    statusT  status0;
    statusT  status1;
    statusT  statusNext;
    lineReqT req0Q;
    lineReqT req1Q;
    logic    valid0Q;
    logic    valid1Q;
    statusT  statusQ;

    function automatic statusT lookupStatus(input tlbResultT r, input logic isWrite);
        statusT s;
        s.tlbMiss = ~r.hit;
        s.protFault = r.hit & (~r.present | (isWrite & ~r.writable));
        s.uncached = r.hit & r.cacheDisable;
        return s;
    endfunction

    always_comb begin
        next0.valid = validIn;
        next0.write = write;
        next0.vAddr = split.vAddr0;
        next0.pAddr = {tlb0.frame, split.vAddr0[pageBits-1:0]};
        next0.data = split.data0;
        next0.mask = split.mask0;

        next1.valid = validIn & split.needSecond;
        next1.write = write;
        next1.vAddr = split.vAddr1;
        next1.pAddr = {tlb1.frame, split.vAddr1[pageBits-1:0]};
        next1.data = split.data1;
        next1.mask = split.mask1;
    end

    assign status0 = lookupStatus(tlb0, write);
    assign status1 = lookupStatus(tlb1, write);

    // second lookup only counts for a split access; idle cycles report nothing
    always_comb begin
        statusNext = '0;
        if (validIn) begin
            statusNext = status0 | (split.needSecond ? status1 : statusT'('0));
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid0Q <= 1'b0;
            valid1Q <= 1'b0;
            statusQ <= '0;
        end else begin
            valid0Q <= next0.valid;
            valid1Q <= next1.valid;
            statusQ <= statusNext;
        end
    end

    // payload only loads when a request is launched
    always_ff @(posedge clk) begin
        if (next0.valid) begin
            req0Q <= next0;
            req1Q <= next1;
        end
    end

    // valid bits come from the reset flops
    always_comb begin
        req0 = req0Q;
        req0.valid = valid0Q;
        req1 = req1Q;
        req1.valid = valid1Q;
    end

    assign tlbMiss = statusQ.tlbMiss;
    assign protFault = statusQ.protFault;
    assign uncached = statusQ.uncached;

endmodule

// ==== source/memAlignTop.sv ====
`timescale 1ns/10ps

module memAlignTop import alignPkg::*; #(
    parameter int tlbEntries = 8
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          validIn,
    input  logic                          write,
    input  logic                          fromBus,
    input  vAddrT                         vAddr,
    input  sizeCodeT                      size,
    input  lineDataT                      dataIn,
    input  logic                          tlbWe,
    input  logic [$clog2(tlbEntries)-1:0] tlbWriteIndex,
    input  tlbEntryT                      tlbWriteEntry,
    output lineReqT                       req0,
    output lineReqT                       req1,
    output logic                          tlbMiss,
    output logic                          protFault,
    output logic                          uncached
);

    splitT     split;
    vpnT       vpn0;
    vpnT       vpn1;
    tlbResultT tlb0;
    tlbResultT tlb1;

    accessSplitter splitter (
        .vAddr   (vAddr),
        .size    (size),
        .dataIn  (dataIn),
        .fromBus (fromBus),
        .split   (split),
        .vpn0    (vpn0),
        .vpn1    (vpn1)
    );

    // one table, looked up for both lines in the same cycle
    tlbTable #(
        .tlbEntries (tlbEntries)
    ) tlb (
        .clk        (clk),
        .rstN       (rstN),
        .we         (tlbWe),
        .writeIndex (tlbWriteIndex),
        .writeEntry (tlbWriteEntry),
        .vpn0       (vpn0),
        .vpn1       (vpn1),
        .result0    (tlb0),
        .result1    (tlb1)
    );

    alignStage stage (
        .clk       (clk),
        .rstN      (rstN),
        .validIn   (validIn),
        .write     (write),
        .split     (split),
        .tlb0      (tlb0),
        .tlb1      (tlb1),
        .req0      (req0),
        .req1      (req1),
        .tlbMiss   (tlbMiss),
        .protFault (protFault),
        .uncached  (uncached)
    );

endmodule

// ==== source/tlbTable.sv ====
`timescale 1ns/10ps

module tlbTable import alignPkg::*; #(
    parameter int tlbEntries = 8
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          we,
    input  logic [$clog2(tlbEntries)-1:0] writeIndex,
    input  tlbEntryT                      writeEntry,
    input  vpnT                           vpn0,
    input  vpnT                           vpn1,
    output tlbResultT                     result0,
    output tlbResultT                     result1
);

    tlbEntryT entries [tlbEntries];

    // write port, entry visible to lookups from the next cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < tlbEntries; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[writeIndex] <= writeEntry;
        end
    end

    // fully associative match; scanning downward lets the lowest index win
    function automatic tlbResultT lookup(input vpnT vpn);
        tlbResultT res;
        res = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].vpn == vpn) begin
                res.hit = 1'b1;
                res.present = entries[i].present;
                res.writable = entries[i].writable;
                res.cacheDisable = entries[i].cacheDisable;
                res.frame = entries[i].frame;
            end
        end
        return res;
    endfunction

    // two independent read ports, one per line of a split access
    always_comb begin
        result0 = lookup(vpn0);
        result1 = lookup(vpn1);
    end

endmodule

// ==== tb/memAlignTb.sv ====
`timescale 1ns/10ps

module memAlignTb import alignPkg::*; ();

    localparam int tlbEntries = 8;
    localparam int indexBits = $clog2(tlbEntries);

    // one expected result and the falling edge it is due at
    typedef struct packed {
        lineReqT     req0;
        lineReqT     req1;
        logic        hit0;
        logic        hit1;
        logic        tlbMiss;
        logic        protFault;
        logic        uncached;
        logic [31:0] due;
    } expectT;

    logic                 clk;
    logic                 rstN;
    logic                 validIn;
    logic                 write;
    logic                 fromBus;
    vAddrT                vAddr;
    sizeCodeT             size;
    lineDataT             dataIn;
    logic                 tlbWe;
    logic [indexBits-1:0] tlbWriteIndex;
    tlbEntryT             tlbWriteEntry;
    lineReqT              req0;
    lineReqT              req1;
    logic                 tlbMiss;
    logic                 protFault;
    logic                 uncached;

    tlbEntryT    tlbModel [tlbEntries];
    expectT      expQ [$];
    logic [31:0] rngState;
    int          negCount;
    int          mismatchCount;
    int          otherErrors;

    memAlignTop #(.tlbEntries(tlbEntries)) DUT (
        .clk           (clk),
        .rstN          (rstN),
        .validIn       (validIn),
        .write         (write),
        .fromBus       (fromBus),
        .vAddr         (vAddr),
        .size          (size),
        .dataIn        (dataIn),
        .tlbWe         (tlbWe),
        .tlbWriteIndex (tlbWriteIndex),
        .tlbWriteEntry (tlbWriteEntry),
        .req0          (req0),
        .req1          (req1),
        .tlbMiss       (tlbMiss),
        .protFault     (protFault),
        .uncached      (uncached)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // xorshift32 step on the shared state
    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic lineDataT randomLine();
        lineDataT d;
        for (int i = 0; i < 4; i++) begin
            d[32*i +: 32] = nextRandom();
        end
        return d;
    endfunction

    // first matching entry from index 0 upward
    function automatic tlbResultT tlbRef(input vpnT vpn);
        tlbResultT r;
        r = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            if (!r.hit && tlbModel[i].valid && tlbModel[i].vpn == vpn) begin
                r.hit = 1'b1;
                r.present = tlbModel[i].present;
                r.writable = tlbModel[i].writable;
                r.cacheDisable = tlbModel[i].cacheDisable;
                r.frame = tlbModel[i].frame;
            end
        end
        return r;
    endfunction

    function automatic expectT refModel(input logic valid, input logic wr, input vAddrT addr,
                                        input sizeCodeT sz, input lineDataT data,
                                        input logic bus);
        expectT    e;
        tlbResultT t0;
        tlbResultT t1;
        vAddrT     base0;
        vAddrT     base1;
        int        offset;
        int        bytes;
        int        bytes0;
        int        bytes1;
        logic      second;
        e = '0;
        offset = int'(addr[3:0]);
        bytes = 1 << sz;
        second = !bus && (offset + bytes > lineBytes);
        bytes0 = second ? lineBytes - offset : bytes;
        bytes1 = bytes - bytes0;
        base0 = {addr[31:4], 4'h0};
        base1 = base0 + 32'd16;
        // byte by byte placement in both lines
        for (int b = 0; b < lineBytes; b++) begin
            if (bus) begin
                e.req0.mask[b] = 1'b1;
                e.req0.data[8*b +: 8] = data[8*b +: 8];
            end else begin
                e.req0.mask[b] = (b >= offset) && (b < offset + bytes0);
                if (b >= offset) begin
                    e.req0.data[8*b +: 8] = data[8*(b-offset) +: 8];
                end
            end
            e.req1.mask[b] = !bus && (b < bytes1);
            if (b + bytes0 < lineBytes) begin
                e.req1.data[8*b +: 8] = data[8*(b+bytes0) +: 8];
            end
        end
        e.req0.valid = valid;
        e.req0.write = wr;
        e.req0.vAddr = base0;
        e.req1.valid = valid && second;
        e.req1.write = wr;
        e.req1.vAddr = base1;
        t0 = tlbRef(base0[31:12]);
        t1 = tlbRef(base1[31:12]);
        e.hit0 = t0.hit;
        e.hit1 = t1.hit;
        e.req0.pAddr = {t0.frame, base0[11:0]};
        e.req1.pAddr = {t1.frame, base1[11:0]};
        // second lookup counts only for a split access
        if (valid) begin
            e.tlbMiss = !t0.hit || (second && !t1.hit);
            e.protFault = (t0.hit && (!t0.present || (wr && !t0.writable)))
                || (second && t1.hit && (!t1.present || (wr && !t1.writable)));
            e.uncached = (t0.hit && t0.cacheDisable) || (second && t1.hit && t1.cacheDisable);
        end
        return e;
    endfunction

    task automatic checkReq(input string name, input lineReqT act, input lineReqT exp,
                            input logic frameKnown);
        if (act.valid !== exp.valid) begin
            mismatchCount++;
            $display("MISMATCH %s.valid: got %h expected %h", name, act.valid, exp.valid);
        end
        // payload only meaningful while valid
        if (exp.valid) begin
            if (act.write !== exp.write) begin
                mismatchCount++;
                $display("MISMATCH %s.write: got %h expected %h", name, act.write, exp.write);
            end
            if (act.vAddr !== exp.vAddr) begin
                mismatchCount++;
                $display("MISMATCH %s.vAddr: got %h expected %h", name, act.vAddr, exp.vAddr);
            end
            if (act.pAddr[11:0] !== exp.pAddr[11:0]
                    || (frameKnown && act.pAddr !== exp.pAddr)) begin
                mismatchCount++;
                $display("MISMATCH %s.pAddr: got %h expected %h", name, act.pAddr, exp.pAddr);
            end
            if (act.mask !== exp.mask) begin
                mismatchCount++;
                $display("MISMATCH %s.mask: got %h expected %h", name, act.mask, exp.mask);
            end
            if (act.data !== exp.data) begin
                mismatchCount++;
                $display("MISMATCH %s.data: got %h expected %h", name, act.data, exp.data);
            end
        end
    endtask

    task automatic checkFlag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s: got %h expected %h", name, act, exp);
        end
    endtask

    // results come out after the next rising edge, so compare on the falling edge after it
    initial begin : compareResults
        expectT e;
        forever begin
            @(negedge clk);
            negCount++;
            while (expQ.size() > 0 && int'(expQ[0].due) <= negCount) begin
                e = expQ.pop_front();
                if (int'(e.due) < negCount) begin
                    otherErrors++;
                    $display("result due at falling edge %0d was not compared", e.due);
                end else begin
                    checkReq("req0", req0, e.req0, e.hit0);
                    checkReq("req1", req1, e.req1, e.hit1);
                    checkFlag("tlbMiss", tlbMiss, e.tlbMiss);
                    checkFlag("protFault", protFault, e.protFault);
                    checkFlag("uncached", uncached, e.uncached);
                end
            end
        end
    end

    task automatic driveAccess(input logic valid, input logic wr, input vAddrT addr,
                               input sizeCodeT sz, input lineDataT data, input logic bus);
        expectT e;
        @(posedge clk);
        e = refModel(valid, wr, addr, sz, data, bus);
        e.due = negCount + 2;
        expQ.push_back(e);
        validIn <= valid;
        write <= wr;
        vAddr <= addr;
        size <= sz;
        dataIn <= data;
        fromBus <= bus;
    endtask

    task automatic driveIdle(input int n);
        for (int i = 0; i < n; i++) begin
            driveAccess(1'b0, 1'b0, '0, '0, '0, 1'b0);
        end
    endtask

    task automatic waitForReset();
        int n;
        n = 0;
        while (rstN !== 1'b1 && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (rstN !== 1'b1) begin
            otherErrors++;
            $display("reset was not released within 10 cycles");
        end
    endtask

    task automatic checkIdleOutputs();
        @(negedge clk);
        checkFlag("req0.valid", req0.valid, 1'b0);
        checkFlag("req1.valid", req1.valid, 1'b0);
        checkFlag("tlbMiss", tlbMiss, 1'b0);
        checkFlag("protFault", protFault, 1'b0);
        checkFlag("uncached", uncached, 1'b0);
    endtask

    // pages 0 to 5 valid, 2 and 5 read-only, 3 not present, 4 and 5 uncached
    task automatic loadTlb();
        tlbEntryT ent;
        for (int i = 0; i < tlbEntries; i++) begin
            ent = '0;
            ent.valid = (i < 6);
            ent.present = (i != 3);
            ent.writable = (i != 2) && (i != 5);
            ent.cacheDisable = (i == 4) || (i == 5);
            ent.vpn = vpnT'(i);
            ent.frame = frameT'(7 - i);
            tlbModel[i] = ent;
            @(posedge clk);
            tlbWe <= 1'b1;
            tlbWriteIndex <= indexBits'(i);
            tlbWriteEntry <= ent;
        end
        @(posedge clk);
        tlbWe <= 1'b0;
    endtask

    // every size at every offset of one line on page 0 back to back
    task automatic sweepInLine();
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < lineBytes; off++) begin
                driveAccess(1'b1, off[0], 32'h0000_0030 | vAddrT'(off), sizeCodeT'(s),
                            randomLine(), 1'b0);
            end
        end
    endtask

    task automatic crossPages();
        driveAccess(1'b1, 1'b1, 32'h0000_0FF9, 2'd3, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b1, 32'h0000_1FFC, 2'd3, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b0, 32'h0000_1FFE, 2'd2, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b0, 32'h0000_5FFF, 2'd1, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b0, 32'h0000_2FFA, 2'd3, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b1, 32'h0000_4FF8, 2'd3, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b0, 32'h0000_7FF9, 2'd3, randomLine(), 1'b0);
    endtask

    task automatic busFills();
        driveAccess(1'b1, 1'b0, 32'h0000_1234, 2'd3, randomLine(), 1'b1);
        driveAccess(1'b1, 1'b1, 32'h0000_0FFF, 2'd3, randomLine(), 1'b1);
        driveAccess(1'b1, 1'b0, 32'h0000_6010, 2'd0, randomLine(), 1'b1);
        driveAccess(1'b1, 1'b1, 32'h0000_4FF8, 2'd2, randomLine(), 1'b1);
    endtask

    task automatic statusCases();
        driveAccess(1'b1, 1'b0, 32'h0000_6100, 2'd2, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b1, 32'h0000_7204, 2'd1, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b1, 32'h0000_2040, 2'd2, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b0, 32'h0000_2040, 2'd2, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b0, 32'h0000_3008, 2'd3, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b0, 32'h0000_4100, 2'd0, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b1, 32'h0000_5300, 2'd3, randomLine(), 1'b0);
        driveAccess(1'b1, 1'b1, 32'h0000_4104, 2'd2, randomLine(), 1'b0);
    endtask

    task automatic randomAccesses(input int n);
        logic [31:0] r;
        logic [7:0]  lineIdx;
        vAddrT       addr;
        for (int i = 0; i < n; i++) begin
            r = nextRandom();
            // a quarter of them in the last line of a page
            lineIdx = (r[4:3] == 2'b00) ? 8'hFF : r[12:5];
            addr = {17'h0, r[2:0], lineIdx, r[16:13]};
            driveAccess(r[26:24] != 3'b000, r[19], addr, r[18:17], randomLine(),
                        r[23:21] == 3'b000);
        end
    endtask

    task automatic drainResults();
        int n;
        n = 0;
        while (expQ.size() > 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (expQ.size() > 0) begin
            otherErrors++;
            $display("%0d expected results were never compared", expQ.size());
        end
    endtask

    initial begin
        rngState = 32'd17954;
        rstN = 1'b0;
        validIn = 1'b0;
        write = 1'b0;
        fromBus = 1'b0;
        vAddr = '0;
        size = '0;
        dataIn = '0;
        tlbWe = 1'b0;
        tlbWriteIndex = '0;
        tlbWriteEntry = '0;
        mismatchCount = 0;
        otherErrors = 0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        waitForReset();
        checkIdleOutputs();
        loadTlb();
        driveIdle(2);
        sweepInLine();
        driveIdle(1);
        crossPages();
        busFills();
        statusCases();
        driveIdle(2);
        randomAccesses(300);
        driveIdle(2);
        drainResults();
        $display("errors: %0d mismatches, %0d assertion failures, %0d other",
                 mismatchCount, DUT.sva.failCount, otherErrors);
        if (mismatchCount == 0 && DUT.sva.failCount == 0 && otherErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/memAlign_sva.sv ====
`timescale 1ns/10ps

module memAlignSva import alignPkg::*; (
    input logic    clk,
    input logic    rstN,
    input logic    validIn,
    input lineReqT req0,
    input lineReqT req1,
    input logic    tlbMiss,
    input logic    protFault,
    input logic    uncached
);

    int failCount;

    // a second line never goes out on its own
    secondNeedsFirst: assert property (@(posedge clk) disable iff (!rstN)
        req1.valid |-> req0.valid)
        else begin
            $error("req1.valid is high while req0.valid is low");
            failCount++;
        end

    // status only while a request is out
    flagsNeedValid: assert property (@(posedge clk) disable iff (!rstN)
        (tlbMiss || protFault || uncached) |-> req0.valid)
        else begin
            $error("status flag is high while req0.valid is low");
            failCount++;
        end

    // one register stage from validIn to req0.valid
    validOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        req0.valid == $past(validIn))
        else begin
            $error("req0.valid does not follow validIn one cycle later");
            failCount++;
        end

endmodule

bind memAlignTop memAlignSva sva (
    .clk       (clk),
    .rstN      (rstN),
    .validIn   (validIn),
    .req0      (req0),
    .req1      (req1),
    .tlbMiss   (tlbMiss),
    .protFault (protFault),
    .uncached  (uncached)
);
